// ==== Makefile ====
SIM      := verilator
TOP      := tb_quad_unit_filter_mac
FILELIST := vlog.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

# exit status of the simulation binary is the pass or fail result
test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== include/qfm_cfg.svh ====
`ifndef QFM_CFG_SVH
`define QFM_CFG_SVH

// array shape
`define QFM_QUAD        4   // compute subunits, one per bus byte lane
`define QFM_NUM_FILTERS 4   // filters held by each subunit
`define QFM_KERNEL_LEN  9   // taps per filter

// datapath widths
`define QFM_DATA_W      8   // one weight or one neuron
`define QFM_BUS_W       32  // QFM_QUAD lanes of QFM_DATA_W
`define QFM_TAP_W       4   // must cover QFM_KERNEL_LEN - 1
`define QFM_FILT_W      2   // must cover QFM_NUM_FILTERS - 1

// growth: 16-bit product plus 4 bits for 9 terms
`define QFM_ACC_W       20
// sum of QFM_QUAD accumulators needs 2 more bits
`define QFM_SUM_W       22

`endif

// ==== src/mac_bank.sv ====
`timescale 1ns/1ps
`include "qfm_cfg.svh"

module mac_bank (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          subunit_en_i,
	input  logic [`QFM_NUM_FILTERS-1:0]   mac_en_i,      // one per filter
	input  logic                          clear_i,       // stage finish
	input  qfm_pkg::neuron_t              neuron_i,      // shared by all subunits
	input  qfm_pkg::weight_vec_t          tap_weights_i,
	output qfm_pkg::acc_vec_t             acc_o
);

	logic [`QFM_NUM_FILTERS-1:0] filt_en;
	qfm_pkg::prod_t              prod [`QFM_NUM_FILTERS];
	qfm_pkg::acc_vec_t           acc_q;

	// a disabled subunit masks every filter
	assign filt_en = mac_en_i & {`QFM_NUM_FILTERS{subunit_en_i}};

	// signed products with one multiplier per filter
	always_comb begin
		for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
			prod[f] = $signed(tap_weights_i[f]) * $signed(neuron_i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i || clear_i) begin
			acc_q <= '0;  // clear wins over any enable
		end else begin
			for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
				if (filt_en[f]) begin
					// product sign extended into the accumulator width
					acc_q[f] <= acc_q[f] + qfm_pkg::acc_t'(prod[f]);
				end
			end
		end
	end

	assign acc_o = acc_q;

	// controller must not accumulate in the stage finish cycle
	a_clear_vs_mac: assert property (
		@(posedge clk) disable iff (rst_i)
		clear_i |-> (mac_en_i == '0)
	) else $error("mac_bank clear and mac enable in the same cycle");

endmodule

// ==== src/qfm_pkg.sv ====
`include "qfm_cfg.svh"

package qfm_pkg;

	// operands
	typedef logic signed [`QFM_DATA_W-1:0] weight_t;
	typedef logic signed [`QFM_DATA_W-1:0] neuron_t;

	// full precision product of one weight and one neuron
	typedef logic signed [2*`QFM_DATA_W-1:0] prod_t;

	typedef logic signed [`QFM_ACC_W-1:0] acc_t;  // per filter, per subunit
	typedef logic signed [`QFM_SUM_W-1:0] sum_t;  // per filter, all subunits

	// one entry per filter, elements keep their signed named type
	typedef acc_t [`QFM_NUM_FILTERS-1:0] acc_vec_t;
	typedef sum_t [`QFM_NUM_FILTERS-1:0] sum_vec_t;
	typedef weight_t [`QFM_NUM_FILTERS-1:0] weight_vec_t;

endpackage

// ==== src/quad_accumulator_adder.sv ====
`timescale 1ns/1ps
`include "qfm_cfg.svh"

module quad_accumulator_adder (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              stage_finish_i,
	input  qfm_pkg::acc_vec_t acc_i [`QFM_QUAD],  // one vector per subunit
	output qfm_pkg::sum_vec_t result_o,
	output logic              result_valid_o
);

	qfm_pkg::sum_vec_t sum_d;

	// add all subunits per filter after sign extension
	always_comb begin
		sum_d = '0;
		for (int u = 0; u < `QFM_QUAD; u++) begin
			for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
				sum_d[f] = sum_d[f] + qfm_pkg::sum_t'(acc_i[u][f]);
			end
		end
	end

	// results captured from the accumulator values before the clearing edge
	always_ff @(posedge clk) begin
		if (rst_i) begin
			result_o <= '0;
		end else if (stage_finish_i) begin
			result_o <= sum_d;
		end
	end

	// single cycle strobe after each stage finish
	always_ff @(posedge clk) begin
		if (rst_i) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= stage_finish_i;
		end
	end

	// valid only stretches when the controller finished twice in a row
	a_valid_pulse: assert property (
		@(posedge clk) disable iff (rst_i)
		(result_valid_o && $past(result_valid_o))
		|-> ($past(stage_finish_i) && $past(stage_finish_i, 2))
	) else $error("result_valid_o high two cycles without two stage finishes");

endmodule

// ==== src/quad_unit_filter_mac.sv ====
`timescale 1ns/1ps
`include "qfm_cfg.svh"

module quad_unit_filter_mac (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic [`QFM_BUS_W-1:0]         data_bus_i,     // byte lane u feeds subunit u
	input  qfm_pkg::neuron_t              neuron_i,
	input  logic [`QFM_QUAD-1:0]          subunit_en_i,
	input  logic [`QFM_QUAD-1:0]          fetch_en_i,     // weight write, per subunit
	input  logic [`QFM_FILT_W-1:0]        filter_sel_i,   // weight write filter index
	input  logic [`QFM_TAP_W-1:0]         tap_i,          // kernel tap for fetch and MAC
	input  logic [`QFM_NUM_FILTERS-1:0]   mac_en_i,
	input  logic                          stage_finish_i,
	output qfm_pkg::sum_vec_t             result_o,
	output logic                          result_valid_o
);

	// per subunit paths between pool, MAC bank and adder
	qfm_pkg::weight_vec_t tap_weights [`QFM_QUAD];
	qfm_pkg::acc_vec_t    acc         [`QFM_QUAD];

	genvar u;
	generate
		for (u = 0; u < `QFM_QUAD; u++) begin : g_sub

			// filter weights of subunit u
			weight_pool u_pool (
				.clk           (clk),
				.rst_i         (rst_i),
				.wr_en_i       (fetch_en_i[u]),
				.wr_data_i     (data_bus_i[u*`QFM_DATA_W +: `QFM_DATA_W]),
				.filter_sel_i  (filter_sel_i),
				.tap_i         (tap_i),
				.tap_weights_o (tap_weights[u])
			);

			// accumulators of subunit u, cleared at stage finish
			mac_bank u_mac (
				.clk           (clk),
				.rst_i         (rst_i),
				.subunit_en_i  (subunit_en_i[u]),
				.mac_en_i      (mac_en_i),
				.clear_i       (stage_finish_i),
				.neuron_i      (neuron_i),
				.tap_weights_i (tap_weights[u]),
				.acc_o         (acc[u])
			);

		end
	endgenerate

	// cross subunit sum, registered on the same edge that clears the banks
	quad_accumulator_adder u_adder (
		.clk            (clk),
		.rst_i          (rst_i),
		.stage_finish_i (stage_finish_i),
		.acc_i          (acc),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

endmodule

// ==== src/weight_pool.sv ====
`timescale 1ns/1ps
`include "qfm_cfg.svh"

module weight_pool (
	input  logic                     clk,
	input  logic                     rst_i,
	input  logic                     wr_en_i,      // fetch enable of this subunit
	input  qfm_pkg::weight_t         wr_data_i,    // this subunit's bus byte lane
	input  logic [`QFM_FILT_W-1:0]   filter_sel_i,
	input  logic [`QFM_TAP_W-1:0]    tap_i,        // write and read tap index
	output qfm_pkg::weight_vec_t     tap_weights_o
);

	localparam logic [`QFM_TAP_W-1:0] LAST_TAP = `QFM_TAP_W'(`QFM_KERNEL_LEN - 1);

	// filter major storage with one row per filter
	qfm_pkg::weight_t mem [`QFM_NUM_FILTERS][`QFM_KERNEL_LEN];

	logic tap_in_range;

	assign tap_in_range = (tap_i <= LAST_TAP);

	// one weight written per cycle
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
				for (int t = 0; t < `QFM_KERNEL_LEN; t++) begin
					mem[f][t] <= '0;
				end
			end
		end else if (wr_en_i && tap_in_range) begin
			mem[filter_sel_i][tap_i] <= wr_data_i;
		end
	end

	// read is combinational and column wise, so every filter's MAC
	// sees its weight for the current tap in the same cycle
	always_comb begin
		for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
			if (tap_in_range) begin
				tap_weights_o[f] = mem[f][tap_i];
			end else begin
				tap_weights_o[f] = '0;  // out of kernel taps read as zero
			end
		end
	end

	// a write beyond the kernel would be silently dropped
	a_wr_tap_range: assert property (
		@(posedge clk) disable iff (rst_i)
		wr_en_i |-> tap_in_range
	) else $error("weight_pool write to tap %0d beyond kernel", tap_i);

endmodule

// ==== tb/tb_quad_unit_filter_mac.sv ====
`timescale 1ns/1ps
`include "qfm_cfg.svh"

module tb_quad_unit_filter_mac;

	localparam int CLK_PERIOD      = 10;
	localparam int NUM_STAGES      = 10;
	localparam int FETCH_CYCLES    = `QFM_NUM_FILTERS * `QFM_KERNEL_LEN;  // one weight per cycle
	localparam int WATCHDOG_CYCLES = NUM_STAGES * (FETCH_CYCLES + `QFM_KERNEL_LEN + 4) + 50;

	logic                          clk = 1'b0;
	logic                          rst_i;
	logic [`QFM_BUS_W-1:0]         data_bus_i;
	qfm_pkg::neuron_t              neuron_i;
	logic [`QFM_QUAD-1:0]          subunit_en_i;
	logic [`QFM_QUAD-1:0]          fetch_en_i;
	logic [`QFM_FILT_W-1:0]        filter_sel_i;
	logic [`QFM_TAP_W-1:0]         tap_i;
	logic [`QFM_NUM_FILTERS-1:0]   mac_en_i;
	logic                          stage_finish_i;
	qfm_pkg::sum_vec_t             result_o;
	logic                          result_valid_o;

	// shadow of the weight pools and accumulators
	qfm_pkg::weight_t  w_ref   [`QFM_QUAD][`QFM_NUM_FILTERS][`QFM_KERNEL_LEN];
	int                acc_ref [`QFM_QUAD][`QFM_NUM_FILTERS];
	qfm_pkg::sum_vec_t exp_q   [$];  // one entry per stage finish in flight
	qfm_pkg::sum_vec_t held;         // what result_o should show right now
	integer            seed;

	quad_unit_filter_mac dut0 (
		.clk            (clk),
		.rst_i          (rst_i),
		.data_bus_i     (data_bus_i),
		.neuron_i       (neuron_i),
		.subunit_en_i   (subunit_en_i),
		.fetch_en_i     (fetch_en_i),
		.filter_sel_i   (filter_sel_i),
		.tap_i          (tap_i),
		.mac_en_i       (mac_en_i),
		.stage_finish_i (stage_finish_i),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	// expected sum of every subunit's accumulated products per filter
	function automatic qfm_pkg::sum_vec_t expected_result();
		qfm_pkg::sum_vec_t r;
		int                s;
		for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
			s = 0;
			for (int u = 0; u < `QFM_QUAD; u++) begin
				s += acc_ref[u][f];
			end
			r[f] = qfm_pkg::sum_t'(s);
		end
		return r;
	endfunction

	task automatic clear_controls();
		data_bus_i     = '0;
		neuron_i       = '0;
		subunit_en_i   = '0;
		fetch_en_i     = '0;
		filter_sel_i   = '0;
		tap_i          = '0;
		mac_en_i       = '0;
		stage_finish_i = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			clear_controls();
		end
	endtask

	// fill every filter and tap; only lanes with their bit set are written
	task automatic write_weights(input logic [`QFM_QUAD-1:0] lanes);
		logic [`QFM_BUS_W-1:0] word;
		for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
			for (int t = 0; t < `QFM_KERNEL_LEN; t++) begin
				@(negedge clk);
				clear_controls();
				word         = rand_word();  // other lanes carry noise
				data_bus_i   = word;
				fetch_en_i   = lanes;
				filter_sel_i = f[`QFM_FILT_W-1:0];
				tap_i        = t[`QFM_TAP_W-1:0];
				for (int u = 0; u < `QFM_QUAD; u++) begin
					if (lanes[u]) begin
						w_ref[u][f][t] = word[u*`QFM_DATA_W +: `QFM_DATA_W];
					end
				end
			end
		end
	endtask

	task automatic mac_cycle(
		input logic [`QFM_QUAD-1:0]        sub_en,
		input logic [`QFM_NUM_FILTERS-1:0] men,
		input int                          t,
		input qfm_pkg::neuron_t            n
	);
		@(negedge clk);
		clear_controls();
		subunit_en_i = sub_en;
		mac_en_i     = men;
		tap_i        = t[`QFM_TAP_W-1:0];
		neuron_i     = n;
		// a product counts only where both the subunit and the filter are enabled
		for (int u = 0; u < `QFM_QUAD; u++) begin
			for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
				if (sub_en[u] && men[f]) begin
					acc_ref[u][f] += int'(w_ref[u][f][t]) * int'(n);
				end
			end
		end
	endtask

	// all taps in order with random neurons and optionally random filter enables
	task automatic run_kernel(input logic [`QFM_QUAD-1:0] sub_en, input logic rand_filters);
		logic [31:0]                 r;
		logic [`QFM_NUM_FILTERS-1:0] men;
		qfm_pkg::neuron_t            n;
		for (int t = 0; t < `QFM_KERNEL_LEN; t++) begin
			r = rand_word();
			n = r[`QFM_DATA_W-1:0];
			if (rand_filters) begin
				men = r[`QFM_DATA_W +: `QFM_NUM_FILTERS];
			end else begin
				men = {`QFM_NUM_FILTERS{1'b1}};
			end
			mac_cycle(sub_en, men, t, n);
		end
	endtask

	// filter f sits out every tap whose index modulo the filter count is f
	task automatic run_kernel_rotating_gate();
		logic [31:0]                 r;
		logic [`QFM_NUM_FILTERS-1:0] men;
		for (int t = 0; t < `QFM_KERNEL_LEN; t++) begin
			r   = rand_word();
			men = ~(`QFM_NUM_FILTERS'(1) << (t % `QFM_NUM_FILTERS));
			mac_cycle({`QFM_QUAD{1'b1}}, men, t, r[`QFM_DATA_W-1:0]);
		end
	endtask

	task automatic finish_stage();
		@(negedge clk);
		clear_controls();
		stage_finish_i = 1'b1;
		exp_q.push_back(expected_result());
		for (int u = 0; u < `QFM_QUAD; u++) begin
			for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
				acc_ref[u][f] = 0;  // accumulators clear on the same edge
			end
		end
	endtask

	task automatic check_result(input int f, input qfm_pkg::sum_t exp, input qfm_pkg::sum_t act);
		if (act !== exp) begin
			$display("Mismatch result_o[%0d]: expected %h, got %h", f, exp, act);
			$display("Test FAILED");
			$fatal(1, "result compare failed");
		end
	endtask

	task automatic check_valid(input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch result_valid_o: expected %h, got %h", exp, act);
			$display("Test FAILED");
			$fatal(1, "valid strobe compare failed");
		end
	endtask

	// inputs are read at the rising edge, outputs at the falling edge
	initial begin : compare_proc
		logic fin_seen;
		held = '0;
		forever begin
			@(posedge clk);
			fin_seen = stage_finish_i && !rst_i;
			@(negedge clk);
			check_valid(fin_seen, result_valid_o);
			if (fin_seen) begin
				if (exp_q.size() == 0) begin
					$display("stage finish seen with no expected result queued");
					$display("Test FAILED");
					$fatal(1, "expected queue empty");
				end else begin
					held = exp_q.pop_front();
				end
			end
			// result_o must hold between valids
			for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
				check_result(f, held[f], result_o[f]);
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed  = 32'h7df6;
		rst_i = 1'b1;
		clear_controls();
		for (int u = 0; u < `QFM_QUAD; u++) begin
			for (int f = 0; f < `QFM_NUM_FILTERS; f++) begin
				acc_ref[u][f] = 0;
				for (int t = 0; t < `QFM_KERNEL_LEN; t++) begin
					w_ref[u][f][t] = '0;
				end
			end
		end
		repeat (3) @(negedge clk);
		rst_i = 1'b0;

		// empty stage right after reset gives zeros
		idle_cycles(4);
		finish_stage();
		idle_cycles(2);

		// weights come out of reset as zero so every product is zero
		run_kernel({`QFM_QUAD{1'b1}}, 1'b0);
		finish_stage();
		idle_cycles(2);

		// full convolution with every lane loaded
		write_weights({`QFM_QUAD{1'b1}});
		run_kernel({`QFM_QUAD{1'b1}}, 1'b0);
		finish_stage();
		idle_cycles(2);

		run_kernel(4'b0110, 1'b0);  // subunits 0 and 3 off
		finish_stage();
		idle_cycles(2);

		run_kernel({`QFM_QUAD{1'b1}}, 1'b1);  // random filter gating per tap
		finish_stage();
		idle_cycles(2);

		run_kernel_rotating_gate();
		finish_stage();
		idle_cycles(2);

		// back to back stages where the second starts right after the finish
		run_kernel({`QFM_QUAD{1'b1}}, 1'b1);
		finish_stage();
		run_kernel(4'b1011, 1'b0);
		finish_stage();
		finish_stage();  // nothing accumulated since the last finish
		idle_cycles(2);

		// reload subunit 2 only
		write_weights(4'b0100);
		run_kernel({`QFM_QUAD{1'b1}}, 1'b0);
		finish_stage();
		idle_cycles(3);

		while (exp_q.size() != 0) @(negedge clk);
		@(negedge clk);
		$display("Test OK");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
src/qfm_pkg.sv
src/weight_pool.sv
src/mac_bank.sv
src/quad_accumulator_adder.sv
src/quad_unit_filter_mac.sv
tb/tb_quad_unit_filter_mac.sv
